//--- source/nocFlitPkg.sv
package nocFlitPkg;

  //////////////////////////////////////////////////
  // Flit type codes.
  //////////////////////////////////////////////////

  typedef logic [2:0] flitTypeT;

  localparam flitTypeT flitHead = 3'd1;
  localparam flitTypeT flitBody = 3'd2;

  localparam int lengthWidth = 12;

  //////////////////////////////////////////////////
  // Flit layouts of 16 bits each.
  //////////////////////////////////////////////////

  // Length counts every flit including the head.
  typedef struct packed
  {
    flitTypeT flitType;
    logic [lengthWidth-1:0] length;
    logic reserved;
  } headFieldsT;

  typedef struct packed
  {
    flitTypeT flitType;
    logic [12:0] payload;
  } bodyFieldsT;

  // Type field sits in the same bits in both views.
  typedef union packed
  {
    headFieldsT head;
    bodyFieldsT body;
  } flitT;

endpackage

//--- source/nocRouterPkg.sv
package nocRouterPkg;

  //////////////////////////////////////////////////
  // Input ports of the output port.
  //////////////////////////////////////////////////

  localparam int numPorts = 5;

  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast = 2;
  localparam int portWest = 3;
  localparam int portSouth = 4;

  //////////////////////////////////////////////////
  // Grant coding.
  //////////////////////////////////////////////////

  // One bit per input with at most one set.
  typedef logic [numPorts-1:0] grantT;

  localparam grantT grantIdle = '0; // No input owns the output.

endpackage

//--- source/grantBus.sv
`timescale 1ns/1ps

interface grantBus;

  nocRouterPkg::grantT req;      // Raw input valids.
  nocRouterPkg::grantT grant;    // Current owner of the output.
  nocRouterPkg::grantT fire;     // Per input transfer strobe.
  nocFlitPkg::flitT fireFlit;    // Flit crossing this cycle.

  // Arbiter side.
  modport arbiter
  (
    input req,
    input fire,
    input fireFlit,
    output grant
  );

  // Data path side.
  modport switch
  (
    input grant,
    output req,
    output fire,
    output fireFlit
  );

endinterface

//--- source/packetTimer.sv
`timescale 1ns/1ps

module packetTimer
(
  input logic clk,
  input logic rst,
  input logic load,
  input logic [nocFlitPkg::lengthWidth-1:0] length,
  input logic step,
  output logic done
);

  logic [nocFlitPkg::lengthWidth-1:0] count;
  logic [nocFlitPkg::lengthWidth-1:0] target;
  logic [nocFlitPkg::lengthWidth-1:0] curTarget;
  logic [nocFlitPkg::lengthWidth-1:0] nextCount;

  // Head transfer uses the fresh length.
  always_comb
  begin
    curTarget = load ? length : target;
    if (curTarget == '0)
      curTarget = nocFlitPkg::lengthWidth'(1); // Zero length means one flit.
  end

  // A head always starts a new packet.
  assign nextCount = (load ? {nocFlitPkg::lengthWidth{1'b0}} : count) + 1'b1;

  assign done = step && (nextCount == curTarget);

  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (step)
      count <= done ? '0 : nextCount; // Clear for the next head.
  end

  always_ff @(posedge clk)
  begin
    if (load)
      target <= length;
  end

endmodule

//--- source/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter
(
  input logic clk,
  input logic rst,
  grantBus.arbiter bus
);

  nocRouterPkg::grantT state;
  nocRouterPkg::grantT nextState;
  logic [nocRouterPkg::numPorts-1:0] load;
  logic [nocRouterPkg::numPorts-1:0] done;
  logic headFire;
  logic packetEnd;
  int curPort;

  // Start has the highest priority and start-1 the lowest.
  function automatic nocRouterPkg::grantT pickFrom
  (
    input nocRouterPkg::grantT cand,
    input int start
  );
    nocRouterPkg::grantT pick;
    int idx;
    pick = nocRouterPkg::grantIdle;
    for (int k = nocRouterPkg::numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % nocRouterPkg::numPorts;
      if (cand[idx])
      begin
        pick = nocRouterPkg::grantIdle;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  //////////////////////////////////////////////////
  // One packet timer per input.
  //////////////////////////////////////////////////

  assign headFire = bus.fireFlit.head.flitType == nocFlitPkg::flitHead;
  assign load = bus.fire & {nocRouterPkg::numPorts{headFire}};

  for (genvar i = 0; i < nocRouterPkg::numPorts; i++)
  begin : genTimer
    packetTimer timer
    (
      .clk(clk),
      .rst(rst),
      .load(load[i]),
      .length(bus.fireFlit.head.length),
      .step(bus.fire[i]),
      .done(done[i])
    );
  end

  //////////////////////////////////////////////////
  // Grant state machine.
  //////////////////////////////////////////////////

  always_comb
  begin
    curPort = 0;
    for (int i = 0; i < nocRouterPkg::numPorts; i++)
    begin
      if (state[i])
        curPort = i;
    end
  end

  assign packetEnd = |(done & state); // Last flit of the owner crosses.

  always_comb
  begin
    nextState = state;
    if (state == nocRouterPkg::grantIdle)
      nextState = pickFrom(bus.req, nocRouterPkg::portLocal);
    else if (packetEnd)
    begin
      // The owner's valid still belongs to its last flit, so it is masked.
      // With no other requester the port goes idle.
      nextState = pickFrom(bus.req & ~state, (curPort + 1) % nocRouterPkg::numPorts);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocRouterPkg::grantIdle;
    else
      state <= nextState;
  end

  assign bus.grant = state;

endmodule

//--- source/outputSwitch.sv
`timescale 1ns/1ps

module outputSwitch
(
  grantBus.switch bus,
  input logic [nocRouterPkg::numPorts-1:0] inValid,
  input nocFlitPkg::flitT [nocRouterPkg::numPorts-1:0] inFlit,
  output logic [nocRouterPkg::numPorts-1:0] inReady,
  output logic outValid,
  output nocFlitPkg::flitT outFlit,
  input logic outReady
);

  //////////////////////////////////////////////////
  // Output multiplexer.
  //////////////////////////////////////////////////

  // Grant is one-hot, so at most one input matches.
  always_comb
  begin
    outValid = 1'b0;
    outFlit = '0;
    for (int i = 0; i < nocRouterPkg::numPorts; i++)
    begin
      if (bus.grant[i])
      begin
        outValid = inValid[i];
        outFlit = inFlit[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Ready return and transfer events.
  //////////////////////////////////////////////////

  assign inReady = bus.grant & {nocRouterPkg::numPorts{outReady}};

  assign bus.fire = inValid & inReady;    // Only the owner can fire.
  assign bus.fireFlit = outFlit;
  assign bus.req = inValid;

endmodule

//--- source/routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort
(
  input logic clk,
  input logic rst,
  input logic [nocRouterPkg::numPorts-1:0] inValid,
  input nocFlitPkg::flitT [nocRouterPkg::numPorts-1:0] inFlit,
  output logic [nocRouterPkg::numPorts-1:0] inReady,
  output logic outValid,
  output nocFlitPkg::flitT outFlit,
  input logic outReady,
  output nocRouterPkg::grantT grant
);

  grantBus bus();

  //////////////////////////////////////////////////
  // Control path.
  //////////////////////////////////////////////////

  outputArbiter arbiter
  (
    .clk(clk),
    .rst(rst),
    .bus(bus.arbiter)
  );

  //////////////////////////////////////////////////
  // Data path.
  //////////////////////////////////////////////////

  outputSwitch switcher
  (
    .bus(bus.switch),
    .inValid(inValid),
    .inFlit(inFlit),
    .inReady(inReady),
    .outValid(outValid),
    .outFlit(outFlit),
    .outReady(outReady)
  );

  assign grant = bus.grant; // Exposed for observation.

endmodule

//--- tb/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period.
  end

  // Released one ns after the tenth edge.
  initial
  begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

//--- tb/routerOutputPort_chk.sv
`timescale 1ns/1ps

module routerOutputPort_chk
(
  input logic clk,
  input logic rst,
  input nocRouterPkg::grantT grant,
  input logic outValid,
  input logic outReady,
  input logic [nocRouterPkg::numPorts-1:0] inReady
);

  //////////////////////////////////////////////////
  // Grant coding.
  //////////////////////////////////////////////////

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant is neither one-hot nor idle");

  validNeedsGrant: assert property (@(posedge clk) disable iff (rst)
    outValid |-> grant != nocRouterPkg::grantIdle)
    else $error("outValid high while no input holds the grant");

  //////////////////////////////////////////////////
  // Handshake.
  //////////////////////////////////////////////////

  // A stalled flit keeps its owner.
  grantHoldsOnStall: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> $stable(grant))
    else $error("grant changed while the output was stalled");

  readyInGrant: assert property (@(posedge clk) disable iff (rst)
    (inReady & ~grant) == '0)
    else $error("inReady set on an input that has no grant");

endmodule

//--- tb/routerOutputPort_tb.sv
`timescale 1ns/1ps

module routerOutputPort_tb;

  localparam int ports = nocRouterPkg::numPorts;
  localparam int packetsPerPort = 40;
  localparam int maxLength = 6;
  localparam int maxFlits = packetsPerPort * maxLength;
  localparam int totalPackets = ports * packetsPerPort;
  localparam int timeoutNs = 10 * 10 + totalPackets * maxLength * 4 * 10;

  logic clk;
  logic rst;
  logic [ports-1:0] inValid;
  nocFlitPkg::flitT [ports-1:0] inFlit;
  logic [ports-1:0] inReady;
  logic outValid;
  nocFlitPkg::flitT outFlit;
  logic outReady;
  nocRouterPkg::grantT grant;

  // One flit stream per input.
  logic [15:0] flits [ports][maxFlits];
  logic lastFlag [ports][maxFlits];
  int flitCount [ports];
  int pos [ports];      // Next flit to present.
  int recvCnt [ports];  // Flits seen on the output.
  int gap [ports];      // Idle cycles before the next packet.
  logic [ports-1:0] fired;

  int modelOwner;       // -1 while idle.
  int modelLeft;
  int pktPort;
  int pktLeft;
  int packetsDone;
  int flitsDone;
  int errorCount;
  int unsigned lcgState;

  tbClock clockGen
  (
    .clk(clk),
    .rst(rst)
  );

  routerOutputPort uut
  (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inFlit(inFlit),
    .inReady(inReady),
    .outValid(outValid),
    .outFlit(outFlit),
    .outReady(outReady),
    .grant(grant)
  );

  bind routerOutputPort routerOutputPort_chk chk
  (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .outValid(outValid),
    .outReady(outReady),
    .inReady(inReady)
  );

  //////////////////////////////////////////////////
  // Helpers.
  //////////////////////////////////////////////////

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return (lcgState >> 16) & 32'h7fff;
  endfunction

  function automatic int randBelow(input int unsigned n);
    return int'(nextRand() % n);
  endfunction

  function automatic logic [ports-1:0] grantFor(input int port);
    logic [ports-1:0] v;
    v = '0;
    if (port >= 0)
      v[port] = 1'b1;
    return v;
  endfunction

  // Lowest index wins with Local first.
  function automatic int firstByPriority(input logic [ports-1:0] valid);
    for (int i = 0; i < ports; i++)
    begin
      if (valid[i])
        return i;
    end
    return -1;
  endfunction

  // Search starts after cur; the finished owner is not a candidate.
  function automatic int nextByRotation(input logic [ports-1:0] valid, input int cur);
    int p;
    for (int k = 1; k < ports; k++)
    begin
      p = (cur + k) % ports;
      if (valid[p])
        return p;
    end
    return -1;
  endfunction

  function automatic logic allDelivered();
    for (int i = 0; i < ports; i++)
    begin
      if (recvCnt[i] != flitCount[i])
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic logMismatch(input string testName, input logic [31:0] expVal,
                             input logic [31:0] actVal);
    $display("ERROR %s: expected %0h, actual %0h at %0d ns", testName, expVal, actVal, $time);
    errorCount++;
  endtask

  task automatic logFailure(input string what);
    $display("%s at %0d ns", what, $time);
    errorCount++;
  endtask

  //////////////////////////////////////////////////
  // Stimulus.
  //////////////////////////////////////////////////

  task automatic buildPackets();
    int len;
    int n;
    for (int p = 0; p < ports; p++)
    begin
      n = 0;
      for (int k = 0; k < packetsPerPort; k++)
      begin
        len = 1 + randBelow(maxLength);
        for (int f = 0; f < len; f++)
        begin
          if (f == 0)
            flits[p][n] = {3'd1, 12'(len), 1'b0};
          else
            flits[p][n] = {3'd2, 3'(p), 10'(n)}; // Payload is input and sequence.
          lastFlag[p][n] = (f == len - 1);
          n++;
        end
      end
      flitCount[p] = n;
      gap[p] = randBelow(4);
    end
  endtask

  task automatic driveInputs();
    for (int p = 0; p < ports; p++)
    begin
      if (fired[p])
      begin
        if (lastFlag[p][pos[p]])
          gap[p] = randBelow(4);
        pos[p]++;
      end
      else if (gap[p] > 0)
        gap[p]--;
      inValid[p] = (pos[p] < flitCount[p]) && (gap[p] == 0);
      if (inValid[p])
        inFlit[p] = flits[p][pos[p]];
      else
        inFlit[p] = 16'h0;
    end
    outReady = randBelow(4) != 0;
  endtask

  //////////////////////////////////////////////////
  // Checks and reference model.
  //////////////////////////////////////////////////

  task automatic checkCycle();
    logic [ports-1:0] expGrant;
    logic [ports-1:0] srcMask;
    logic expOutValid;
    logic [15:0] expFlit;
    int src;
    expGrant = grantFor(modelOwner);
    srcMask = inValid & inReady;
    expOutValid = |(expGrant & inValid);

    if (grant !== expGrant)
      logMismatch("rotation", 32'(expGrant), 32'(grant));
    if (inReady !== (expGrant & {ports{outReady}}))
      logMismatch("handshake", 32'(expGrant & {ports{outReady}}), 32'(inReady));
    if (outValid !== expOutValid)
      logMismatch("handshake", 32'(expOutValid), 32'(outValid));
    if (!outReady && srcMask != '0)
      logFailure("Handshake failure: an input flit was taken while outReady was low");
    if ($countones(srcMask) > 1)
      logFailure("Handshake failure: more than one input flit was taken in one cycle");
    if ((outValid && outReady) != (srcMask != '0))
      logFailure("Handshake failure: output transfer and input transfer disagree");
    fired = srcMask;

    // Output stream per input and per packet.
    if ($countones(srcMask) == 1)
    begin
      src = firstByPriority(srcMask);
      expFlit = flits[src][recvCnt[src]];
      if (outFlit !== expFlit)
        logMismatch("ordering", 32'(expFlit), 32'(outFlit));
      if (pktLeft > 0 && src != pktPort)
        logMismatch("integrity", pktPort, src);
      if (expFlit[15:13] == 3'd1)
      begin
        pktPort = src;
        pktLeft = int'(expFlit[12:1]);
      end
      if (pktLeft > 0)
      begin
        pktLeft--;
        if (pktLeft == 0)
          packetsDone++;
      end
      recvCnt[src]++;
      flitsDone++;
    end

    // Expected grant after the coming edge.
    if (modelOwner < 0)
      modelOwner = firstByPriority(inValid);
    else if (outReady && expOutValid)
    begin
      expFlit = flits[modelOwner][pos[modelOwner]];
      if (expFlit[15:13] == 3'd1)
        modelLeft = int'(expFlit[12:1]);
      modelLeft--;
      if (modelLeft == 0)
        modelOwner = nextByRotation(inValid, modelOwner);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog.
  //////////////////////////////////////////////////

  initial
  begin
    lcgState = 67;
    inValid = '0;
    inFlit = '0;
    outReady = 1'b0;
    fired = '0;
    modelOwner = -1;
    modelLeft = 0;
    pktPort = 0;
    pktLeft = 0;
    packetsDone = 0;
    flitsDone = 0;
    errorCount = 0;
    for (int p = 0; p < ports; p++)
    begin
      pos[p] = 0;
      recvCnt[p] = 0;
    end
    buildPackets();

    @(negedge rst);
    @(negedge clk);
    if (grant !== nocRouterPkg::grantIdle)
      logMismatch("reset", 32'(nocRouterPkg::grantIdle), 32'(grant));
    if (outValid !== 1'b0)
      logMismatch("reset", 32'h0, 32'(outValid));
    if (inReady !== '0)
      logMismatch("reset", 32'h0, 32'(inReady));

    // Drive after the edge and sample mid cycle.
    while (!allDelivered())
    begin
      @(posedge clk);
      #1;
      driveInputs();
      @(negedge clk);
      checkCycle();
    end

    if (packetsDone != totalPackets)
      logMismatch("completion", totalPackets, packetsDone);
    $display("Summary: %0d packets, %0d flits, %0d errors", packetsDone, flitsDone,
             errorCount);
    if (errorCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(timeoutNs);
    $display("Timeout: not all packets were delivered within %0d ns", timeoutNs);
    $display("tests failed");
    $finish;
  end

endmodule

//--- routerOutputPort.f
source/nocFlitPkg.sv
source/nocRouterPkg.sv
source/grantBus.sv
source/packetTimer.sv
source/outputArbiter.sv
source/outputSwitch.sv
source/routerOutputPort.sv
tb/tbClock.sv
tb/routerOutputPort_chk.sv
tb/routerOutputPort_tb.sv

//--- Makefile
TOP = routerOutputPort_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f routerOutputPort.f

# Passes only when the pass line appears in the simulation output.
run: build
	./obj_dir/V$(TOP) | awk '{ print } /^all tests passed$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f routerOutputPort.f

clean:
	rm -rf obj_dir
